//--- hw/vmem_pkg.sv
package vmem_pkg;

  localparam int WIDTH   = 32;  // data word width.
  localparam int NUMVBNK = 8;   // number of single-port banks.
  localparam int BITVBNK = 3;
  localparam int NUMVROW = 64;  // rows in each bank.
  localparam int BITVROW = 6;

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [BITVBNK-1:0] bank_t;
  typedef logic [BITVROW-1:0] row_t;

  // One spare word per row, tagged with the bank it belongs to.
  typedef struct packed {
    logic  vld;
    bank_t bank;
    word_t data;
  } spare_t;

endpackage

//--- hw/vmem_bank.sv
`timescale 1ns/1ps

module vmem_bank #(
  parameter int DRAM_DELAY = 2
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            read,
  input  logic            write,
  input  vmem_pkg::row_t  addr,
  input  vmem_pkg::word_t din,
  output vmem_pkg::word_t dout
);

  import vmem_pkg::*;

  word_t mem     [NUMVROW];
  word_t rd_pipe [DRAM_DELAY];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DRAM_DELAY; i++) begin
        rd_pipe[i] <= '0;
      end
    end else begin
      if (read) begin
        rd_pipe[0] <= mem[addr];  // samples the word before any write in this cycle.
      end
      for (int i = 1; i < DRAM_DELAY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign dout = rd_pipe[DRAM_DELAY-1];

endmodule

//--- hw/vmem_bank_mux.sv
`timescale 1ns/1ps

module vmem_bank_mux #(
  parameter int DRAM_DELAY = 2
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            phy_read,
  input  vmem_pkg::bank_t phy_rdbank,
  input  vmem_pkg::row_t  phy_rdrow,
  input  logic            phy_write,
  input  vmem_pkg::bank_t phy_wrbank,
  input  vmem_pkg::row_t  phy_wrrow,
  input  vmem_pkg::word_t phy_din,
  output vmem_pkg::word_t phy_dout
);

  import vmem_pkg::*;

  logic [NUMVBNK-1:0] bank_read;
  logic [NUMVBNK-1:0] bank_write;
  row_t               bank_addr  [NUMVBNK];
  word_t              bank_dout  [NUMVBNK];
  bank_t              rdbank_dly [DRAM_DELAY];

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    assign bank_read[b]  = phy_read && (phy_rdbank == bank_t'(b));
    assign bank_write[b] = phy_write && (phy_wrbank == bank_t'(b));
    assign bank_addr[b]  = bank_write[b] ? phy_wrrow : phy_rdrow;  // a written bank takes the write row.

    vmem_bank #(
      .DRAM_DELAY(DRAM_DELAY)
    ) i_vmem_bank (
      .clk   (clk),
      .reset (reset),
      .read  (bank_read[b]),
      .write (bank_write[b]),
      .addr  (bank_addr[b]),
      .din   (phy_din),
      .dout  (bank_dout[b])
    );
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DRAM_DELAY; i++) begin
        rdbank_dly[i] <= '0;
      end
    end else begin
      rdbank_dly[0] <= phy_rdbank;
      for (int i = 1; i < DRAM_DELAY; i++) begin
        rdbank_dly[i] <= rdbank_dly[i-1];
      end
    end
  end

  assign phy_dout = bank_dout[rdbank_dly[DRAM_DELAY-1]];  // lines up with the bank read latency.

endmodule

//--- hw/vmem_spare_store.sv
`timescale 1ns/1ps

module vmem_spare_store (
  input  logic             clk,
  input  logic             reset,
  input  logic             sp_rd1,
  input  vmem_pkg::row_t   sp_row1,
  output vmem_pkg::spare_t sp_q1,
  input  logic             sp_rd2,
  input  vmem_pkg::row_t   sp_row2,
  output vmem_pkg::spare_t sp_q2,
  input  logic             sp_write,
  input  vmem_pkg::row_t   sp_wrrow,
  input  vmem_pkg::spare_t sp_din
);

  import vmem_pkg::*;

  spare_t tbl [NUMVROW];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUMVROW; i++) begin
        tbl[i].vld <= 1'b0;  // bank and data fields keep whatever they held.
      end
    end else if (sp_write) begin
      tbl[sp_wrrow] <= sp_din;
    end
  end

  // Both ports read the table as it stood before this cycle's write.
  always_ff @(posedge clk) begin
    if (sp_rd1) begin
      sp_q1 <= tbl[sp_row1];
    end
  end

  always_ff @(posedge clk) begin
    if (sp_rd2) begin
      sp_q2 <= tbl[sp_row2];
    end
  end

endmodule

//--- hw/vmem_ctrl.sv
`timescale 1ns/1ps

module vmem_ctrl #(
  parameter int DRAM_DELAY = 2
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             pread,
  input  vmem_pkg::bank_t  prdbadr,
  input  vmem_pkg::row_t   prdradr,
  input  logic             pwrite,
  input  vmem_pkg::bank_t  pwrbadr,
  input  vmem_pkg::row_t   pwrradr,
  input  vmem_pkg::word_t  pdin,
  output vmem_pkg::word_t  pdout,
  output logic             pdout_vld,
  output logic             phy_read,
  output vmem_pkg::bank_t  phy_rdbank,
  output vmem_pkg::row_t   phy_rdrow,
  output logic             phy_write,
  output vmem_pkg::bank_t  phy_wrbank,
  output vmem_pkg::row_t   phy_wrrow,
  output vmem_pkg::word_t  phy_din,
  input  vmem_pkg::word_t  phy_dout,
  output logic             sp_rd1,
  output vmem_pkg::row_t   sp_row1,
  input  vmem_pkg::spare_t sp_q1,
  output logic             sp_rd2,
  output vmem_pkg::row_t   sp_row2,
  input  vmem_pkg::spare_t sp_q2,
  output logic             sp_write,
  output vmem_pkg::row_t   sp_wrrow,
  output vmem_pkg::spare_t sp_din
);

  import vmem_pkg::*;

  logic   rd_vld_q;
  bank_t  rd_bank_q;
  row_t   rd_row_q;
  logic   wr_vld_q;
  bank_t  wr_bank_q;
  row_t   wr_row_q;
  word_t  wr_din_q;
  logic   upd_vld;
  row_t   upd_row;
  spare_t upd_ent;
  spare_t rd_ent;
  spare_t wr_ent;
  logic   rd_hit;
  logic   collide;
  logic   evict;
  logic   vld_pipe [DRAM_DELAY];
  logic   hit_pipe [DRAM_DELAY];
  word_t  dat_pipe [DRAM_DELAY];

  assign sp_rd1  = pread;
  assign sp_row1 = prdradr;
  assign sp_rd2  = pwrite;
  assign sp_row2 = pwrradr;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld_q <= 1'b0;
      wr_vld_q <= 1'b0;
      upd_vld  <= 1'b0;
    end else begin
      rd_vld_q <= pread;
      wr_vld_q <= pwrite;
      upd_vld  <= sp_write;
    end
  end

  always_ff @(posedge clk) begin
    rd_bank_q <= prdbadr;
    rd_row_q  <= prdradr;
    wr_bank_q <= pwrbadr;
    wr_row_q  <= pwrradr;
    wr_din_q  <= pdin;
    upd_row   <= sp_wrrow;
    upd_ent   <= sp_din;
  end

  // last cycle's update is not yet visible in the returned entries.
  assign rd_ent = (upd_vld && (upd_row == rd_row_q)) ? upd_ent : sp_q1;
  assign wr_ent = (upd_vld && (upd_row == wr_row_q)) ? upd_ent : sp_q2;

  assign rd_hit  = rd_vld_q && rd_ent.vld && (rd_ent.bank == rd_bank_q);
  assign collide = wr_vld_q && phy_read && (wr_bank_q == rd_bank_q);
  assign evict   = collide && wr_ent.vld && (wr_ent.bank != wr_bank_q);

  assign phy_read   = rd_vld_q && !rd_hit;
  assign phy_rdbank = rd_bank_q;
  assign phy_rdrow  = rd_row_q;

  always_comb begin
    phy_write  = collide ? evict : wr_vld_q;  // a collision frees the evicted word's bank.
    phy_wrbank = evict ? wr_ent.bank : wr_bank_q;
    phy_wrrow  = wr_row_q;
    phy_din    = evict ? wr_ent.data : wr_din_q;
    sp_write   = 1'b0;
    sp_wrrow   = wr_row_q;
    sp_din     = '{vld: 1'b1, bank: wr_bank_q, data: wr_din_q};
    if (collide) begin
      sp_write = 1'b1;
    end else if (wr_vld_q && wr_ent.vld && (wr_ent.bank == wr_bank_q)) begin
      sp_write   = 1'b1;  // the bank now holds the newer word.
      sp_din.vld = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DRAM_DELAY; i++) begin
        vld_pipe[i] <= 1'b0;
      end
    end else begin
      vld_pipe[0] <= rd_vld_q;
      for (int i = 1; i < DRAM_DELAY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    hit_pipe[0] <= rd_hit;
    dat_pipe[0] <= rd_ent.data;
    for (int i = 1; i < DRAM_DELAY; i++) begin
      hit_pipe[i] <= hit_pipe[i-1];
      dat_pipe[i] <= dat_pipe[i-1];
    end
  end

  assign pdout_vld = vld_pipe[DRAM_DELAY-1];
  assign pdout     = hit_pipe[DRAM_DELAY-1] ? dat_pipe[DRAM_DELAY-1] : phy_dout;

endmodule

//--- hw/vmem_top.sv
`timescale 1ns/1ps

module vmem_top #(
  parameter int DRAM_DELAY = 2
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            pread,
  input  vmem_pkg::bank_t prdbadr,
  input  vmem_pkg::row_t  prdradr,
  input  logic            pwrite,
  input  vmem_pkg::bank_t pwrbadr,
  input  vmem_pkg::row_t  pwrradr,
  input  vmem_pkg::word_t pdin,
  output vmem_pkg::word_t pdout,
  output logic            pdout_vld
);

  import vmem_pkg::*;

  logic   phy_read;
  bank_t  phy_rdbank;
  row_t   phy_rdrow;
  logic   phy_write;
  bank_t  phy_wrbank;
  row_t   phy_wrrow;
  word_t  phy_din;
  word_t  phy_dout;
  logic   sp_rd1;
  row_t   sp_row1;
  spare_t sp_q1;
  logic   sp_rd2;
  row_t   sp_row2;
  spare_t sp_q2;
  logic   sp_write;
  row_t   sp_wrrow;
  spare_t sp_din;

  vmem_ctrl #(
    .DRAM_DELAY(DRAM_DELAY)
  ) i_vmem_ctrl (
    .clk        (clk),
    .reset      (reset),
    .pread      (pread),
    .prdbadr    (prdbadr),
    .prdradr    (prdradr),
    .pwrite     (pwrite),
    .pwrbadr    (pwrbadr),
    .pwrradr    (pwrradr),
    .pdin       (pdin),
    .pdout      (pdout),
    .pdout_vld  (pdout_vld),
    .phy_read   (phy_read),
    .phy_rdbank (phy_rdbank),
    .phy_rdrow  (phy_rdrow),
    .phy_write  (phy_write),
    .phy_wrbank (phy_wrbank),
    .phy_wrrow  (phy_wrrow),
    .phy_din    (phy_din),
    .phy_dout   (phy_dout),
    .sp_rd1     (sp_rd1),
    .sp_row1    (sp_row1),
    .sp_q1      (sp_q1),
    .sp_rd2     (sp_rd2),
    .sp_row2    (sp_row2),
    .sp_q2      (sp_q2),
    .sp_write   (sp_write),
    .sp_wrrow   (sp_wrrow),
    .sp_din     (sp_din)
  );

  vmem_bank_mux #(
    .DRAM_DELAY(DRAM_DELAY)
  ) i_vmem_bank_mux (
    .clk        (clk),
    .reset      (reset),
    .phy_read   (phy_read),
    .phy_rdbank (phy_rdbank),
    .phy_rdrow  (phy_rdrow),
    .phy_write  (phy_write),
    .phy_wrbank (phy_wrbank),
    .phy_wrrow  (phy_wrrow),
    .phy_din    (phy_din),
    .phy_dout   (phy_dout)
  );

  vmem_spare_store i_vmem_spare_store (
    .clk      (clk),
    .reset    (reset),
    .sp_rd1   (sp_rd1),
    .sp_row1  (sp_row1),
    .sp_q1    (sp_q1),
    .sp_rd2   (sp_rd2),
    .sp_row2  (sp_row2),
    .sp_q2    (sp_q2),
    .sp_write (sp_write),
    .sp_wrrow (sp_wrrow),
    .sp_din   (sp_din)
  );

endmodule

//--- tb/tb_vmem.sv
`timescale 1ns/1ps

module tb_vmem;

  import vmem_pkg::*;

  localparam int DRAM_DELAY     = 2;
  localparam int LATENCY        = 1 + DRAM_DELAY;
  localparam int RESET_CYCLES   = 5;
  localparam int PRELOAD_CYCLES = NUMVBNK * NUMVROW;
  localparam int BURST_CYCLES   = 24;
  localparam int PLAIN_CYCLES   = 64;
  localparam int COLLIDE_CYCLES = 64 + NUMVBNK * 8;
  localparam int EVICT_CYCLES   = 2 * NUMVBNK;
  localparam int HAZARD_CYCLES  = 8 + 16 + NUMVBNK;
  localparam int RANDOM_CYCLES  = 2000;
  localparam int DRAIN_CYCLES   = LATENCY + 5;
  localparam int STIM_CYCLES    = RESET_CYCLES + 1 + PRELOAD_CYCLES + BURST_CYCLES +
                                  PLAIN_CYCLES + COLLIDE_CYCLES + EVICT_CYCLES +
                                  HAZARD_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  logic  clk;
  logic  reset;
  logic  pread;
  bank_t prdbadr;
  row_t  prdradr;
  logic  pwrite;
  bank_t pwrbadr;
  row_t  pwrradr;
  word_t pdin;
  word_t pdout;
  logic  pdout_vld;

  word_t       model [NUMVBNK][NUMVROW];
  word_t       exp_q [$];
  int unsigned issue_q [$];
  int unsigned cyc = 0;
  word_t       exp_word;
  int unsigned issue_cyc;

  vmem_top #(
    .DRAM_DELAY(DRAM_DELAY)
  ) i_vmem_top (
    .clk       (clk),
    .reset     (reset),
    .pread     (pread),
    .prdbadr   (prdbadr),
    .prdradr   (prdradr),
    .pwrite    (pwrite),
    .pwrbadr   (pwrbadr),
    .pwrradr   (pwrradr),
    .pdin      (pdin),
    .pdout     (pdout),
    .pdout_vld (pdout_vld)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // expected word for a read, taken before a same-cycle write lands.
  function automatic word_t model_word(input bank_t b, input row_t r);
    return model[b][r];
  endfunction

  function automatic word_t fill_word(input bank_t b, input row_t r);
    return {7'h35, b, r, 7'h4b, b, r};
  endfunction

  function automatic bank_t any_bank();
    return bank_t'($urandom_range(NUMVBNK - 1));
  endfunction

  function automatic row_t row_below(input int unsigned n);
    return row_t'($urandom_range(n - 1));
  endfunction

  function automatic word_t any_word();
    return $urandom();
  endfunction

  function automatic logic coin();
    return $urandom_range(3) != 0;  // high three times out of four.
  endfunction

  task automatic drive_cycle(input logic rd, input bank_t rb, input row_t rr, input logic wr,
                             input bank_t wb, input row_t wrow, input word_t data);
    pread   = rd;
    prdbadr = rb;
    prdradr = rr;
    pwrite  = wr;
    pwrbadr = wb;
    pwrradr = wrow;
    pdin    = data;
    if (rd) begin
      exp_q.push_back(model_word(rb, rr));
      issue_q.push_back(cyc);
    end
    if (wr) begin
      model[wb][wrow] = data;
    end
    @(negedge clk);
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, '0);
    end
  endtask

  task automatic read_row(input row_t r);
    for (int b = 0; b < NUMVBNK; b++) begin
      drive_cycle(1'b1, bank_t'(b), r, 1'b0, '0, '0, '0);
    end
  endtask

  task automatic collisions();
    bank_t b;
    for (int i = 0; i < 64; i++) begin
      b = any_bank();
      drive_cycle(1'b1, b, row_below(8), 1'b1, b, row_below(8), any_word());
    end
    for (int r = 0; r < 8; r++) begin
      read_row(row_t'(r));  // includes the banks that were read while being written.
    end
  endtask

  task automatic hazards();
    bank_t b;
    row_t  r;
    for (int i = 0; i < 8; i++) begin
      b = any_bank();
      r = row_below(NUMVROW);
      drive_cycle(1'b1, b, r, 1'b1, b, r, any_word());
    end
    for (int i = 0; i < 16; i++) begin
      drive_cycle(1'b1, any_bank(), row_t'(30), 1'b1, any_bank(), row_t'(30), any_word());
    end
    read_row(row_t'(30));
  endtask

  initial begin
    bank_t rb;
    void'($urandom(32'h8c4d_94be));
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int r = 0; r < NUMVROW; r++) begin
        model[b][r] = '0;
      end
    end
    reset   = 1'b1;
    pread   = 1'b0;
    prdbadr = '0;
    prdradr = '0;
    pwrite  = 1'b0;
    pwrbadr = '0;
    pwrradr = '0;
    pdin    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int r = 0; r < NUMVROW; r++) begin
        drive_cycle(1'b0, '0, '0, 1'b1, bank_t'(b), row_t'(r), fill_word(bank_t'(b), row_t'(r)));
      end
    end
    for (int i = 0; i < BURST_CYCLES; i++) begin
      drive_cycle(1'b1, any_bank(), row_below(NUMVROW), 1'b0, '0, '0, '0);
    end
    for (int i = 0; i < PLAIN_CYCLES; i++) begin
      rb = any_bank();
      drive_cycle(1'b1, rb, row_below(NUMVROW), 1'b1, bank_t'(rb + 1 + $urandom_range(6)),
                  row_below(NUMVROW), any_word());
    end
    collisions();
    // each colliding write to row 20 pushes the previous bank's word home.
    for (int b = 0; b < NUMVBNK; b++) begin
      drive_cycle(1'b1, bank_t'(b), row_t'(21), 1'b1, bank_t'(b), row_t'(20), any_word());
    end
    read_row(row_t'(20));
    hazards();
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      drive_cycle(coin(), any_bank(), row_below(4), coin(), any_bank(), row_below(4), any_word());
    end
    idle(DRAIN_CYCLES);
    if (exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_run($sformatf("%0d reads never returned data", exp_q.size()));
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout after %0d cycles, the run did not finish", cyc));
    end else if (pdout_vld) begin
      if (exp_q.size() == 0) begin
        fail_run("pdout_vld was high with no read outstanding");
      end else begin
        exp_word  = exp_q.pop_front();
        issue_cyc = issue_q.pop_front();
        assert (cyc - issue_cyc == LATENCY) else
          fail_run($sformatf("read data came %0d cycles after its request instead of %0d",
                             cyc - issue_cyc, LATENCY));
        assert (pdout == exp_word) else
          fail_run($sformatf("mismatch pdout expected 0x%08h actual 0x%08h", exp_word, pdout));
      end
    end
  end

endmodule

//--- vmem.f
hw/vmem_pkg.sv
hw/vmem_bank.sv
hw/vmem_bank_mux.sv
hw/vmem_spare_store.sv
hw/vmem_ctrl.sv
hw/vmem_top.sv
tb/tb_vmem.sv

//--- run_sim.sh
#!/bin/sh
# Build the vmem testbench with Verilator, run it and judge the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timescale 1ns/1ps --top-module tb_vmem -f vmem.f

# the simulation exits non-zero on failure, the log decides the result.
./obj_dir/Vtb_vmem > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
